// ==== verilog.f ====
common/cachePkg.sv
dataCache/cacheController.sv
dataCache/cacheWays.sv
dataCache/cacheDatapath.sv
dataCache/dataCacheTop.sv
verif/clockGen.sv
verif/busMemory.sv
verif/dataCache_assertions.sv
verif/dataCacheTb.sv

// ==== Bender.yml ====
package:
  name: data_cache

sources:
  - common/cachePkg.sv
  - dataCache/cacheController.sv
  - dataCache/cacheWays.sv
  - dataCache/cacheDatapath.sv
  - dataCache/dataCacheTop.sv
  - target: test
    files:
      - verif/clockGen.sv
      - verif/busMemory.sv
      - verif/dataCache_assertions.sv
      - verif/dataCacheTb.sv

// ==== verif/dataCacheTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataCacheTb;
  import cachePkg::*;

  localparam int NumSets = 16;
  localparam int MemWords = 4096;
  localparam int DriveDelay = 2;
  // About 50 accesses of up to 40 cycles each plus a 20 beat flush and margin
  localparam int MaxCycles = 4000;

  logic        clk;
  logic        reset;
  logic        cacheEnable;
  logic        flush;
  logic        stall;
  logic        busReady;
  logic [31:0] readData;
  logic [31:0] busReadData;
  logic [31:0] lastAddr;
  cpuReq       cpu;
  busReq       bus;
  busSize      lastSize;
  int          beats;
  int          bursts;
  int          cycleCount = 0;
  logic [31:0] refMem [MemWords];

  clockGen clock_i (.clk(clk), .reset(reset));

  busMemory #(.Depth(MemWords), .Seed(32'hb0139393)) memory_i (
    .clk(clk), .reset(reset), .bus(bus), .busReady(busReady), .busReadData(busReadData),
    .beats(beats), .bursts(bursts), .lastAddr(lastAddr), .lastSize(lastSize)
  );

  dataCacheTop #(.numSets(NumSets)) dut_i (
    .clk(clk), .reset(reset), .cacheEnable(cacheEnable), .flush(flush), .cpu(cpu),
    .busReady(busReady), .busReadData(busReadData), .stall(stall), .readData(readData),
    .bus(bus)
  );

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= MaxCycles) begin
      $display("Timeout after %0d cycles, the DUT never finished the tests", cycleCount);
      $display("Something failed");
      $fatal(1, "timeout");
    end
  end

  task automatic checkValue(input string testName, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected %h, actual %h", testName, expected, actual);
      $display("Something failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic int wordIndex(input logic [31:0] addr);
    return int'(addr[13:2]);
  endfunction

  function automatic logic [31:0] mergeLanes(input logic [31:0] oldWord,
                                             input logic [31:0] newWord,
                                             input logic [3:0] lanes);
    logic [31:0] merged;
    merged = oldWord;
    for (int i = 0; i < 4; i++) begin
      if (lanes[i]) begin
        merged[8*i +: 8] = newWord[8*i +: 8];
      end
    end
    return merged;
  endfunction

  // One lane is a byte, an aligned pair a half word, anything else a word
  function automatic busSize sizeForMask(input logic [3:0] mask);
    if ($countones(mask) == 1) begin
      return sizeByte;
    end
    if (mask == 4'b0011 || mask == 4'b1100) begin
      return sizeHalf;
    end
    return sizeWord;
  endfunction

  function automatic logic [3:0] directLanes(input logic [3:0] mask);
    return (sizeForMask(mask) == sizeWord) ? 4'b1111 : mask;
  endfunction

  // Byte address of a byte or half beat is its first lane
  function automatic logic [1:0] lowestLane(input logic [3:0] mask);
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) begin
        return 2'(i);
      end
    end
    return 2'd0;
  endfunction

  // Holds the request until a cycle with stall low
  task automatic runAccess(input logic isWrite, input logic [31:0] addr, input logic [3:0] mask,
                           input logic [31:0] data, output logic [31:0] result,
                           output int waitCycles);
    @(posedge clk);
    #DriveDelay;
    cpu.read = ~isWrite;
    cpu.write = isWrite;
    cpu.addr = addr;
    cpu.byteMask = mask;
    cpu.writeData = data;
    waitCycles = 0;
    @(negedge clk);
    while (stall) begin
      waitCycles++;
      @(negedge clk);
    end
    result = readData;
    @(posedge clk);
    #DriveDelay;
    cpu.read = 1'b0;
    cpu.write = 1'b0;
  endtask

  task automatic loadCheck(input string testName, input logic [31:0] addr,
                           input logic [3:0] mask, input int expectedBeats);
    logic [31:0] result;
    int          waitCycles;
    int          startBeats;
    startBeats = beats;
    runAccess(1'b0, addr, mask, 32'h0, result, waitCycles);
    checkValue(testName, refMem[wordIndex(addr)], result);
    checkValue(testName, 32'(expectedBeats), 32'(beats - startBeats));
    if (expectedBeats == 0) begin
      checkValue(testName, 32'd0, 32'(waitCycles));
    end
  endtask

  task automatic storeCheck(input string testName, input logic [31:0] addr,
                            input logic [3:0] mask, input logic [31:0] data,
                            input int expectedBeats);
    logic [31:0] result;
    logic [3:0]  lanes;
    int          waitCycles;
    int          startBeats;
    lanes = cacheEnable ? mask : directLanes(mask);
    startBeats = beats;
    runAccess(1'b1, addr, mask, data, result, waitCycles);
    refMem[wordIndex(addr)] = mergeLanes(refMem[wordIndex(addr)], data, lanes);
    checkValue(testName, 32'(expectedBeats), 32'(beats - startBeats));
    if (expectedBeats == 0) begin
      checkValue(testName, 32'd0, 32'(waitCycles));
    end
  endtask

  task automatic memoryCheck(input string testName, input logic [31:0] addr);
    checkValue(testName, refMem[wordIndex(addr)], memory_i.words[wordIndex(addr)]);
  endtask

  task automatic directBeatCheck(input string testName, input logic [31:0] addr,
                                 input logic [3:0] mask);
    busSize      expectedSize;
    logic [31:0] wordAddr;
    expectedSize = sizeForMask(mask);
    wordAddr = {addr[31:2], 2'b00};
    checkValue(testName, 32'(expectedSize), 32'(lastSize));
    if (expectedSize == sizeWord) begin
      checkValue(testName, wordAddr, {lastAddr[31:2], 2'b00});
    end else begin
      checkValue(testName, {addr[31:2], lowestLane(mask)}, lastAddr);
    end
    memoryCheck(testName, addr);
  endtask

  task automatic setEnable(input logic value);
    @(posedge clk);
    #DriveDelay;
    cacheEnable = value;
  endtask

  task automatic pulseFlush();
    @(posedge clk);
    #DriveDelay;
    flush = 1'b1;
    @(posedge clk);
    #DriveDelay;
    flush = 1'b0;
    @(negedge clk);
    while (stall) begin
      @(negedge clk);
    end
  endtask

  task automatic readMissThenHit();
    int startBursts;
    startBursts = bursts;
    loadCheck("readMiss", 32'h0000_0104, 4'b1111, 4);
    checkValue("readMiss", 32'd1, 32'(bursts - startBursts));
    checkValue("readMiss", 32'(sizeWord), 32'(lastSize));
    loadCheck("readHit", 32'h0000_0104, 4'b1111, 0);
    loadCheck("readHit", 32'h0000_010C, 4'b1111, 0);
  endtask

  task automatic byteMaskedStores();
    loadCheck("byteStores", 32'h0000_0210, 4'b1111, 4);
    storeCheck("byteStores", 32'h0000_0210, 4'b0001, 32'h1122_3344, 0);
    storeCheck("byteStores", 32'h0000_0210, 4'b0011, 32'hA5B6_C7D8, 0);
    storeCheck("byteStores", 32'h0000_0218, 4'b1111, 32'hDEAD_BEEF, 0);
    storeCheck("byteStores", 32'h0000_021C, 4'b1100, 32'h0F1E_2D3C, 0);
    for (int i = 0; i < 4; i++) begin
      loadCheck("byteStores", 32'h0000_0210 + 4 * i, 4'b1111, 0);
    end
  endtask

  task automatic dirtyEviction();
    int startBursts;
    storeCheck("dirtyEviction", 32'h0000_0320, 4'b1111, 32'hCAFE_0320, 4);
    storeCheck("dirtyEviction", 32'h0000_032C, 4'b0110, 32'h0BAD_F00D, 0);
    loadCheck("dirtyEviction", 32'h0000_0424, 4'b1111, 4);
    startBursts = bursts;
    // Write-back of the first line followed by the refill
    loadCheck("dirtyEviction", 32'h0000_0528, 4'b1111, 8);
    checkValue("dirtyEviction", 32'd2, 32'(bursts - startBursts));
    for (int i = 0; i < 4; i++) begin
      memoryCheck("dirtyEviction", 32'h0000_0320 + 4 * i);
    end
    loadCheck("dirtyEviction", 32'h0000_032C, 4'b1111, 4);
  endtask

  task automatic lruReplacement();
    loadCheck("lruReplacement", 32'h0000_0630, 4'b1111, 4);
    loadCheck("lruReplacement", 32'h0000_0734, 4'b1111, 4);
    loadCheck("lruReplacement", 32'h0000_0630, 4'b1111, 0);
    loadCheck("lruReplacement", 32'h0000_0838, 4'b1111, 4);
    loadCheck("lruReplacement", 32'h0000_0630, 4'b1111, 0);
    loadCheck("lruReplacement", 32'h0000_0734, 4'b1111, 4);
  endtask

  task automatic disabledCache();
    setEnable(1'b0);
    storeCheck("disabledCache", 32'h0000_0940, 4'b0001, 32'h0000_00AB, 1);
    directBeatCheck("disabledCache", 32'h0000_0940, 4'b0001);
    storeCheck("disabledCache", 32'h0000_0944, 4'b1100, 32'h1234_0000, 1);
    directBeatCheck("disabledCache", 32'h0000_0944, 4'b1100);
    storeCheck("disabledCache", 32'h0000_0948, 4'b1111, 32'h89AB_CDEF, 1);
    directBeatCheck("disabledCache", 32'h0000_0948, 4'b1111);
    storeCheck("disabledCache", 32'h0000_094C, 4'b0110, 32'h5566_7788, 1);
    directBeatCheck("disabledCache", 32'h0000_094C, 4'b0110);
    loadCheck("disabledCache", 32'h0000_0940, 4'b1111, 1);
    directBeatCheck("disabledCache", 32'h0000_0940, 4'b1111);
    loadCheck("disabledCache", 32'h0000_0944, 4'b0010, 1);
    directBeatCheck("disabledCache", 32'h0000_0944, 4'b0010);
    setEnable(1'b1);
    loadCheck("disabledCache", 32'h0000_094C, 4'b1111, 4);
  endtask

  task automatic flushDirtyLines();
    int startBeats;
    storeCheck("flush", 32'h0000_0A50, 4'b1111, 32'h0A50_1111, 4);
    storeCheck("flush", 32'h0000_0B54, 4'b0011, 32'h0000_2222, 4);
    storeCheck("flush", 32'h0000_0C68, 4'b1000, 32'h3300_0000, 4);
    storeCheck("flush", 32'h0000_0D7C, 4'b1111, 32'h0D7C_4444, 4);
    startBeats = beats;
    pulseFlush();
    // Four new dirty lines plus the byte-store line in set 1
    checkValue("flush", 32'd20, 32'(beats - startBeats));
    for (int i = 0; i < MemWords; i++) begin
      memoryCheck("flush", 32'(4 * i));
    end
    loadCheck("flush", 32'h0000_0A50, 4'b1111, 0);
    loadCheck("flush", 32'h0000_0B54, 4'b1111, 0);
    loadCheck("flush", 32'h0000_0C68, 4'b1111, 0);
    loadCheck("flush", 32'h0000_0D7C, 4'b1111, 0);
    loadCheck("flush", 32'h0000_0210, 4'b1111, 0);
  endtask

  initial begin
    cpu = '0;
    cacheEnable = 1'b1;
    flush = 1'b0;
    @(negedge reset);
    for (int i = 0; i < MemWords; i++) begin
      refMem[i] = memory_i.words[i];
    end
    repeat (2) @(posedge clk);

    readMissThenHit();
    byteMaskedStores();
    dirtyEviction();
    lruReplacement();
    disabledCache();
    flushDirtyLines();

    if (dut_i.controller_i.assertions_i.failures == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Something failed");
      $fatal(1, "concurrent assertion failures");
    end
  end

endmodule

`default_nettype wire

// ==== verif/dataCache_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataCacheAssertions (
  input logic                          clk,
  input logic                          reset,
  input logic                          stall,
  input logic                          busRequest,
  input logic                          busWrite,
  input logic                          busReady,
  input logic                          useCount,
  input logic [cachePkg::WordBits-1:0] wordCount,
  input cachePkg::cacheState           state
);
  import cachePkg::*;

  int failures = 0;

  // Idle right after reset
  property idleAfterReset;
    @(posedge clk) $fell(reset) |-> !stall && !busRequest && state == ready;
  endproperty

  // A waiting beat keeps its fields
  property beatHoldsFields;
    @(posedge clk) disable iff (reset)
      busRequest && !busReady |=>
        busRequest && $stable(busWrite) && $stable(wordCount) && $stable(useCount);
  endproperty

  // Write-back beats come from the burst counter and so use word size
  property writeBackWordSize;
    @(posedge clk) disable iff (reset)
      state inside {writeBack, lastWriteBack} |-> useCount;
  endproperty

  idleAfterResetCheck: assert property (idleAfterReset) else begin
    failures++;
    $error("controller not idle after reset");
  end

  beatHoldsFieldsCheck: assert property (beatHoldsFields) else begin
    failures++;
    $error("bus fields changed while a beat was waiting");
  end

  writeBackWordSizeCheck: assert property (writeBackWordSize) else begin
    failures++;
    $error("write-back beat not at word size");
  end

endmodule

bind cacheController dataCacheAssertions assertions_i (
  .clk(clk), .reset(reset), .stall(stall), .busRequest(busRequest), .busWrite(busWrite),
  .busReady(busReady), .useCount(useCount), .wordCount(wordCount), .state(state)
);

`default_nettype wire

// ==== verif/busMemory.sv ====
`timescale 1ns/10ps
`default_nettype none

module busMemory #(
  parameter int Depth = 4096,
  parameter int unsigned Seed = 32'h1
) (
  input  logic             clk,
  input  logic             reset,
  input  cachePkg::busReq  bus,
  output logic             busReady,
  output logic [31:0]      busReadData,
  output int               beats,
  output int               bursts,
  output logic [31:0]      lastAddr,
  output cachePkg::busSize lastSize
);
  import cachePkg::*;

  localparam int AddrBits = $clog2(Depth);

  logic [31:0] words [Depth];
  logic [3:0]  lanes;
  int          runLength;

  assign busReadData = words[bus.addr[AddrBits+1:2]];

  // Byte lanes written by one beat of the given size
  function automatic logic [3:0] laneEnable(input busSize size, input logic [1:0] byteAddr);
    case (size)
      sizeByte: laneEnable = 4'b0001 << byteAddr;
      sizeHalf: laneEnable = byteAddr[1] ? 4'b1100 : 4'b0011;
      default:  laneEnable = 4'b1111;
    endcase
  endfunction

  initial begin
    for (int i = 0; i < Depth; i++) begin
      words[i] = {i[15:0] ^ 16'h5a3c, ~i[15:0]};
    end
    busReady = 1'b0;
    beats = 0;
    bursts = 0;
    runLength = 0;
    lastAddr = '0;
    lastSize = sizeWord;
    void'($urandom(Seed));
    forever begin
      @(posedge clk);
      if (!reset && bus.request && busReady) begin
        beats++;
        runLength++;
        lastAddr = bus.addr;
        lastSize = bus.size;
        if (bus.write) begin
          lanes = laneEnable(bus.size, bus.addr[1:0]);
          for (int i = 0; i < 4; i++) begin
            if (lanes[i]) begin
              words[bus.addr[AddrBits+1:2]][8*i +: 8] <= bus.writeData[8*i +: 8];
            end
          end
        end
        // Last beat of a line-aligned word burst
        if (runLength % 4 == 0 && bus.size == sizeWord && bus.addr[3:2] == 2'b11) begin
          bursts++;
        end
      end
      #1;
      if (!bus.request) begin
        runLength = 0;
      end
      // Wait state on about one beat in four
      busReady = bus.request && ($urandom % 4 != 0);
    end
  end

endmodule

`default_nettype wire

// ==== verif/clockGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
  parameter int HalfPeriod = 20,
  parameter int ResetCycles = 3
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #HalfPeriod clk = ~clk;
  end

  // Reset drops just after the last reset edge
  initial begin
    reset = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== dataCache/dataCacheTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataCacheTop #(
  parameter int numSets = 16
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             cacheEnable,
  input  logic             flush,
  input  cachePkg::cpuReq  cpu,
  input  logic             busReady,
  input  logic [31:0]      busReadData,
  output logic             stall,
  output logic [31:0]      readData,
  output cachePkg::busReq  bus
);
  import cachePkg::*;

  localparam int IndexBits = $clog2(numSets);
  localparam int TagBits = 28 - IndexBits;

  wayStatus             way0;
  wayStatus             way1;
  busSize               beatSize;
  logic                 lruWay;
  logic                 busRequest;
  logic                 busWrite;
  logic                 useCount;
  logic                 refillWrite;
  logic                 storeWrite;
  logic                 victimWay;
  logic                 hitWay;
  logic                 flushActive;
  logic                 cleanLine;
  logic                 fillBeat;
  logic                 lineWrite;
  logic                 touch;
  logic [WordBits-1:0]  wordCount;
  logic [WordBits-1:0]  wordSel;
  logic [IndexBits-1:0] flushIndex;
  logic [IndexBits-1:0] setIndex;
  logic [TagBits-1:0]   requestTag;
  logic [TagBits-1:0]   burstTag;
  logic [31:0]          data0;
  logic [31:0]          data1;
  logic [31:0]          writeWord;
  logic [31:0]          busAddr;
  logic [31:0]          busWriteData;

  assign requestTag = cpu.addr[31 -: TagBits];
  assign setIndex = flushActive ? flushIndex : cpu.addr[ByteBits + WordBits +: IndexBits];

  // Refill beats only, direct reads leave the arrays alone
  assign fillBeat = refillWrite & useCount;
  assign lineWrite = storeWrite | fillBeat;
  assign touch = ~stall & cacheEnable & (cpu.read | cpu.write);

  // Write-back bursts carry the victim tag, refills the request tag
  assign burstTag = busWrite ? (victimWay ? way1.tag[TagBits-1:0] : way0.tag[TagBits-1:0])
                             : requestTag;

  cacheController #(.numSets(numSets)) controller_i (
    .clk(clk), .reset(reset), .cacheEnable(cacheEnable), .flush(flush),
    .cpuRead(cpu.read), .cpuWrite(cpu.write), .cpuTag(requestTag),
    .way0(way0), .way1(way1), .lruWay(lruWay), .busReady(busReady),
    .stall(stall), .busRequest(busRequest), .busWrite(busWrite),
    .useCount(useCount), .wordCount(wordCount), .refillWrite(refillWrite),
    .storeWrite(storeWrite), .victimWay(victimWay), .hitWay(hitWay),
    .flushActive(flushActive), .flushIndex(flushIndex), .cleanLine(cleanLine)
  );

  cacheWays #(.numSets(numSets)) ways_i (
    .clk(clk), .reset(reset), .index(setIndex), .wordSel(wordSel),
    .writeWay(victimWay), .lineWrite(lineWrite), .statusWrite(fillBeat),
    .newTag(requestTag), .setDirty(storeWrite), .cleanLine(cleanLine),
    .touch(touch), .touchWay(hitWay), .writeWord(writeWord),
    .way0(way0), .way1(way1), .lruWay(lruWay), .data0(data0), .data1(data1)
  );

  cacheDatapath #(.numSets(numSets)) datapath_i (
    .cpu(cpu), .useCount(useCount), .wordCount(wordCount),
    .refillWrite(refillWrite), .victimWay(victimWay), .hitWay(hitWay),
    .data0(data0), .data1(data1), .busReadData(busReadData),
    .victimTag(burstTag), .flushActive(flushActive), .flushIndex(flushIndex),
    .wordSel(wordSel), .writeWord(writeWord), .readData(readData),
    .busAddr(busAddr), .busSize(beatSize), .busWriteData(busWriteData)
  );

  assign bus = '{busRequest, busWrite, busAddr, beatSize, busWriteData};

endmodule

`default_nettype wire

// ==== dataCache/cacheDatapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module cacheDatapath #(
  parameter int numSets = 16
) (
  input  cachePkg::cpuReq                cpu,
  input  logic                           useCount,
  input  logic [cachePkg::WordBits-1:0]  wordCount,
  input  logic                           refillWrite,
  input  logic                           victimWay,
  input  logic                           hitWay,
  input  logic [31:0]                    data0,
  input  logic [31:0]                    data1,
  input  logic [31:0]                    busReadData,
  input  logic [27-$clog2(numSets):0]    victimTag,
  input  logic                           flushActive,
  input  logic [$clog2(numSets)-1:0]     flushIndex,
  output logic [cachePkg::WordBits-1:0]  wordSel,
  output logic [31:0]                    writeWord,
  output logic [31:0]                    readData,
  output logic [31:0]                    busAddr,
  output cachePkg::busSize               busSize,
  output logic [31:0]                    busWriteData
);
  import cachePkg::*;

  localparam int IndexBits = $clog2(numSets);

  logic [WordBits-1:0]  addrWord;
  logic [IndexBits-1:0] setIndex;
  logic [ByteBits-1:0]  byteAddr;
  logic [31:0]          victimData;
  logic [31:0]          hitData;
  logic [31:0]          baseWord;
  logic [3:0]           laneMask;

  assign addrWord = cpu.addr[ByteBits +: WordBits];
  assign setIndex = flushActive ? flushIndex : cpu.addr[ByteBits + WordBits +: IndexBits];
  assign wordSel = useCount ? wordCount : addrWord;

  assign victimData = victimWay ? data1 : data0;
  assign hitData = hitWay ? data1 : data0;

  // Store lanes only land on the addressed word
  assign laneMask = (cpu.write && wordSel == addrWord) ? cpu.byteMask : 4'b0000;
  assign baseWord = refillWrite ? busReadData : victimData;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      writeWord[8*i +: 8] = laneMask[i] ? cpu.writeData[8*i +: 8] : baseWord[8*i +: 8];
    end
  end

  // Bus word goes straight out on a direct read
  assign readData = refillWrite ? busReadData : hitData;

  // Lowest enabled lane gives the byte address of a direct beat
  always_comb begin
    if (cpu.byteMask[0]) begin
      byteAddr = 2'd0;
    end else if (cpu.byteMask[1]) begin
      byteAddr = 2'd1;
    end else if (cpu.byteMask[2]) begin
      byteAddr = 2'd2;
    end else begin
      byteAddr = 2'd3;
    end
  end

  always_comb begin
    if (useCount) begin
      busSize = sizeWord;
    end else begin
      case (cpu.byteMask)
        4'b0001, 4'b0010, 4'b0100, 4'b1000: busSize = sizeByte;
        4'b0011, 4'b1100:                   busSize = sizeHalf;
        default:                            busSize = sizeWord;
      endcase
    end
  end

  // Burst beats walk the line from word 0
  assign busAddr = useCount ? {victimTag, setIndex, wordCount, {ByteBits{1'b0}}}
                            : {cpu.addr[31:ByteBits], byteAddr};
  assign busWriteData = useCount ? victimData : cpu.writeData;

endmodule

`default_nettype wire

// ==== dataCache/cacheWays.sv ====
`timescale 1ns/10ps
`default_nettype none

module cacheWays #(
  parameter int numSets = 16
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [$clog2(numSets)-1:0]    index,
  input  logic [cachePkg::WordBits-1:0] wordSel,
  input  logic                          writeWay,
  input  logic                          lineWrite,
  input  logic                          statusWrite,
  input  logic [27-$clog2(numSets):0]   newTag,
  input  logic                          setDirty,
  input  logic                          cleanLine,
  input  logic                          touch,
  input  logic                          touchWay,
  input  logic [31:0]                   writeWord,
  output cachePkg::wayStatus            way0,
  output cachePkg::wayStatus            way1,
  output logic                          lruWay,
  output logic [31:0]                   data0,
  output logic [31:0]                   data1
);
  import cachePkg::*;

  localparam int IndexBits = $clog2(numSets);
  localparam int TagBits = 28 - IndexBits;

  logic [31:0]           lineData [2][numSets][LineWords];
  logic [TagBits-1:0]    tagArray [2][numSets];
  logic [1:0][numSets-1:0] validBits;
  logic [1:0][numSets-1:0] dirtyBits;
  logic [numSets-1:0]    lruBits;
  logic                  install;

  // New line becomes valid with the last refill word
  assign install = statusWrite && (wordSel == WordBits'(LineWords - 1));

  always_ff @(posedge clk) begin
    if (lineWrite) begin
      lineData[writeWay][index][wordSel] <= writeWord;
    end
    if (install) begin
      tagArray[writeWay][index] <= newTag;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
      lruBits <= '0;
    end else begin
      if (install) begin
        validBits[writeWay][index] <= 1'b1;
        dirtyBits[writeWay][index] <= 1'b0;
        lruBits[index] <= ~writeWay;
      end
      if (setDirty) begin
        dirtyBits[writeWay][index] <= 1'b1;
      end
      if (cleanLine) begin
        dirtyBits[writeWay][index] <= 1'b0;
      end
      // LRU bit names the way to replace next
      if (touch) begin
        lruBits[index] <= ~touchWay;
      end
    end
  end

  assign way0 = '{
    valid: validBits[0][index],
    dirty: dirtyBits[0][index],
    tag:   32'(tagArray[0][index])
  };
  assign way1 = '{
    valid: validBits[1][index],
    dirty: dirtyBits[1][index],
    tag:   32'(tagArray[1][index])
  };

  assign lruWay = lruBits[index];
  assign data0 = lineData[0][index][wordSel];
  assign data1 = lineData[1][index][wordSel];

endmodule

`default_nettype wire

// ==== dataCache/cacheController.sv ====
`timescale 1ns/10ps
`default_nettype none

module cacheController #(
  parameter int numSets = 16
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              cacheEnable,
  input  logic                              flush,
  input  logic                              cpuRead,
  input  logic                              cpuWrite,
  input  logic [27-$clog2(numSets):0]       cpuTag,
  input  cachePkg::wayStatus                way0,
  input  cachePkg::wayStatus                way1,
  input  logic                              lruWay,
  input  logic                              busReady,
  output logic                              stall,
  output logic                              busRequest,
  output logic                              busWrite,
  output logic                              useCount,
  output logic [cachePkg::WordBits-1:0]     wordCount,
  output logic                              refillWrite,
  output logic                              storeWrite,
  output logic                              victimWay,
  output logic                              hitWay,
  output logic                              flushActive,
  output logic [$clog2(numSets)-1:0]        flushIndex,
  output logic                              cleanLine
);
  import cachePkg::*;

  localparam int IndexBits = $clog2(numSets);
  localparam int TagBits = 28 - IndexBits;

  cacheState state;
  cacheState nextState;

  logic [WordBits-1:0]  beatCount;
  logic [IndexBits-1:0] flushCount;
  logic                 activeWay;
  logic                 directAccess;
  logic                 flushing;
  logic                 access;
  logic                 hit0;
  logic                 hit1;
  logic                 hit;
  logic                 dirty0;
  logic                 dirty1;
  logic                 pickWay;
  logic                 pickDirty;
  logic                 setHasDirty;
  logic                 flushWay;
  logic                 lastSet;
  logic                 inBurst;

  assign access = cpuRead | cpuWrite;

  // Tag compare on both ways
  assign hit0 = way0.valid & (way0.tag[TagBits-1:0] == cpuTag);
  assign hit1 = way1.valid & (way1.tag[TagBits-1:0] == cpuTag);
  assign hit = cacheEnable & (hit0 | hit1);

  assign dirty0 = way0.valid & way0.dirty;
  assign dirty1 = way1.valid & way1.dirty;

  // Invalid way first, otherwise the least recently used one
  assign pickWay = ~way0.valid ? 1'b0 : (~way1.valid ? 1'b1 : lruWay);
  assign pickDirty = pickWay ? dirty1 : dirty0;

  // Flush scan handles way 0 before way 1
  assign setHasDirty = dirty0 | dirty1;
  assign flushWay = ~dirty0;
  assign lastSet = (flushCount == IndexBits'(numSets - 1));

  assign inBurst = state inside {writeBack, lastWriteBack, memRead, lastRead};

  always_comb begin
    nextState = state;
    case (state)
      ready: begin
        if (flush) begin
          nextState = flushScan;
        end else if (access && !cacheEnable) begin
          nextState = cpuWrite ? directWrite : lastRead;
        end else if (access && !hit) begin
          nextState = pickDirty ? writeBack : memRead;
        end
      end
      writeBack: begin
        if (busReady && beatCount == WordBits'(LineWords - 2)) begin
          nextState = lastWriteBack;
        end
      end
      lastWriteBack: begin
        if (busReady) begin
          nextState = flushing ? flushScan : memRead;
        end
      end
      memRead: begin
        if (busReady && beatCount == WordBits'(LineWords - 2)) begin
          nextState = lastRead;
        end
      end
      lastRead: begin
        if (busReady) begin
          nextState = finish;
        end
      end
      directWrite: begin
        if (busReady) begin
          nextState = finish;
        end
      end
      finish: begin
        nextState = ready;
      end
      flushScan: begin
        if (setHasDirty) begin
          nextState = writeBack;
        end else if (lastSet) begin
          nextState = ready;
        end
      end
      default: begin
        nextState = ready;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= ready;
      beatCount <= '0;
      flushCount <= '0;
      activeWay <= 1'b0;
      directAccess <= 1'b0;
      flushing <= 1'b0;
    end else begin
      state <= nextState;

      // Beat counter only moves when the bus takes a beat
      if (state == ready || state == finish) begin
        beatCount <= '0;
      end else if (inBurst && busReady) begin
        beatCount <= beatCount + 1'b1;
      end

      if (state == ready) begin
        directAccess <= access & ~cacheEnable & ~flush;
        activeWay <= pickWay;
        flushing <= flush;
        flushCount <= '0;
      end else if (state == flushScan) begin
        if (setHasDirty) begin
          activeWay <= flushWay;
        end else if (lastSet) begin
          flushing <= 1'b0;
        end else begin
          flushCount <= flushCount + 1'b1;
        end
      end
    end
  end

  // Direct accesses finish in the beat cycle itself
  always_comb begin
    case (state)
      ready:       stall = flush | (access & ~hit);
      lastRead:    stall = ~(directAccess & busReady);
      directWrite: stall = ~busReady;
      default:     stall = 1'b1;
    endcase
  end

  assign busRequest = inBurst | (state == directWrite);
  assign busWrite = state inside {writeBack, lastWriteBack, directWrite};
  assign useCount = inBurst & ~directAccess;
  assign wordCount = beatCount;

  assign refillWrite = busReady & (state == memRead || state == lastRead);
  assign storeWrite = (state == ready) & cpuWrite & hit & ~flush;

  assign hitWay = hit1;
  // Way under work, the hit way while idle
  assign victimWay = (state == ready) ? (hit ? hit1 : pickWay) : activeWay;

  assign flushActive = flushing;
  assign flushIndex = flushCount;
  assign cleanLine = (state == lastWriteBack) & busReady;

endmodule

`default_nettype wire

// ==== common/cachePkg.sv ====
`default_nettype none

package cachePkg;

  // Line geometry, bursts are always four beats
  localparam int LineWords = 4;
  localparam int WordBits = 2;
  localparam int ByteBits = 2;

  // Controller states
  typedef enum logic [3:0] {
    ready,
    writeBack,
    lastWriteBack,
    memRead,
    lastRead,
    finish,
    flushScan,
    directWrite
  } cacheState;

  // Bus beat size, encoded like an hsize field
  typedef enum logic [2:0] {
    sizeByte = 3'b000,
    sizeHalf = 3'b001,
    sizeWord = 3'b010
  } busSize;

  // Access from the pipeline memory stage
  typedef struct packed {
    logic        read;
    logic        write;
    logic [31:0] addr;
    logic [3:0]  byteMask;
    logic [31:0] writeData;
  } cpuReq;

  // Word bus request, request is a level
  typedef struct packed {
    logic        request;
    logic        write;
    logic [31:0] addr;
    busSize      size;
    logic [31:0] writeData;
  } busReq;

  // Status of one way in the indexed set, tag is right aligned
  typedef struct packed {
    logic        valid;
    logic        dirty;
    logic [31:0] tag;
  } wayStatus;

endpackage

`default_nettype wire
